//--- hw/fpdiv_settings.svh
// ==========================================================================
// Format widths and fixed constants of the single-precision divide unit
// Included by the format package and by every RTL block that slices fields
// ==========================================================================

`ifndef FPDIV_SETTINGS_SVH
`define FPDIV_SETTINGS_SVH

// IEEE 754 single fields
`define FPDIV_EXP_W   8
`define FPDIV_MAN_W   23
`define FPDIV_BIAS    127

// Hidden bit, 23 fraction bits, guard bit and one normalization bit
`define FPDIV_QUOT_W  26

// Canonical quiet NaN, positive, only the top fraction bit set
`define FPDIV_QNAN    32'h7fc0_0000

`endif

//--- hw/fp_format_pkg.sv
// ==========================================================================
// Types describing the IEEE 754 single format and the unpacked operand
// Shared by the classifier, the mantissa divider and the rounding stage
// ==========================================================================

`include "fpdiv_settings.svh"

package fp_format_pkg;

  // Raw operand or result word
  typedef logic [`FPDIV_EXP_W+`FPDIV_MAN_W:0] float_t;

  // Fields of the stored word
  typedef logic [`FPDIV_EXP_W-1:0] exp_t;
  typedef logic [`FPDIV_MAN_W-1:0] frac_t;

  // Significand with hidden bit
  typedef logic [`FPDIV_MAN_W:0] sig_t;

  // Raw quotient out of the divider
  typedef logic [`FPDIV_QUOT_W-1:0] quot_t;

  // Two extra bits, room for both overflow and underflow
  typedef logic signed [`FPDIV_EXP_W+1:0] exp_wide_t;

  // Subnormals are flushed and land in cls_zero
  typedef enum logic [2:0] {
    cls_zero,
    cls_normal,
    cls_inf,
    cls_qnan,
    cls_snan
  } fp_class_e;

  typedef struct packed {
    logic      sign;
    exp_t      exp;
    sig_t      sig;
    fp_class_e cls;
  } fp_unpacked_t;

endpackage

//--- hw/fpdiv_ctrl_pkg.sv
// ==========================================================================
// Control types of the divide unit
// Rounding mode, exception flags and the operation state machine
// ==========================================================================

package fpdiv_ctrl_pkg;

  // RISC-V frm encodings, 5 to 7 round like rtz
  typedef enum logic [2:0] {
    rne = 3'd0,
    rtz = 3'd1,
    rdn = 3'd2,
    rup = 3'd3,
    rmm = 3'd4
  } round_mode_e;

  // Same bit order as fflags, nv on top
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

  typedef enum logic [2:0] {
    idle,
    classify,
    divide,
    round,
    finish
  } div_state_e;

endpackage

//--- hw/fp_classify.sv
// ==========================================================================
// Combinational unpack and classify of one single-precision operand
// One instance per operand, output captured by the top level
// ==========================================================================

`include "fpdiv_settings.svh"

module fp_classify (
  input  fp_format_pkg::float_t       operand,
  output fp_format_pkg::fp_unpacked_t unpacked
);

  fp_format_pkg::exp_t  exp_field;
  fp_format_pkg::frac_t frac_field;
  logic                 exp_ones;
  logic                 exp_zero;

  // Field extraction
  assign exp_field  = operand[`FPDIV_EXP_W+`FPDIV_MAN_W-1:`FPDIV_MAN_W];
  assign frac_field = operand[`FPDIV_MAN_W-1:0];
  assign exp_ones   = &exp_field;
  assign exp_zero   = ~|exp_field;

  always_comb begin
    unpacked.sign = operand[`FPDIV_EXP_W+`FPDIV_MAN_W];
    unpacked.exp  = exp_field;
    // Hidden bit only for normals, flushed values carry no significand
    unpacked.sig  = exp_zero ? '0 : {1'b1, frac_field};

    if (exp_ones) begin
      // Top fraction bit splits quiet from signalling
      if (frac_field == '0) begin
        unpacked.cls = fp_format_pkg::cls_inf;
      end else if (frac_field[`FPDIV_MAN_W-1]) begin
        unpacked.cls = fp_format_pkg::cls_qnan;
      end else begin
        unpacked.cls = fp_format_pkg::cls_snan;
      end
    end else if (exp_zero) begin
      // Zero and subnormal alike
      unpacked.cls = fp_format_pkg::cls_zero;
    end else begin
      unpacked.cls = fp_format_pkg::cls_normal;
    end
  end

endmodule

//--- hw/mant_divider.sv
// ==========================================================================
// Iterative radix-2 restoring divider of two 24-bit significands
// div_start loads and runs the first step, div_done follows 26 cycles later
// Quotient and sticky hold until the next div_start
// ==========================================================================

`include "fpdiv_settings.svh"

module mant_divider (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 div_start,
  input  fp_format_pkg::sig_t  dividend,
  input  fp_format_pkg::sig_t  divisor,
  output logic                 div_done,
  output fp_format_pkg::quot_t quotient,
  output logic                 sticky
);

  localparam int cnt_w = $clog2(`FPDIV_QUOT_W);

  // One bit above the significand, holds the shifted remainder
  typedef logic [`FPDIV_MAN_W+1:0] rem_t;

  logic [cnt_w-1:0]    count;
  rem_t                rem_q;
  fp_format_pkg::sig_t divisor_q;

  rem_t                cur_rem;
  rem_t                diff;
  rem_t                next_rem;
  fp_format_pkg::sig_t cur_div;
  logic                q_bit;
  logic                last_step;

  // ==========================================================================
  // One restoring step
  // ==========================================================================

  // First step works straight on the inputs
  assign cur_rem   = div_start ? rem_t'(dividend) : rem_q;
  assign cur_div   = div_start ? divisor : divisor_q;
  assign diff      = cur_rem - rem_t'(cur_div);
  assign q_bit     = (cur_rem >= rem_t'(cur_div));
  // Restore when the trial subtraction went negative
  assign next_rem  = q_bit ? diff : cur_rem;
  assign last_step = (count == cnt_w'(1));

  // Step counter and done pulse
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      count    <= '0;
      div_done <= 1'b0;
    end else if (div_start) begin
      count    <= cnt_w'(`FPDIV_QUOT_W - 1);
      div_done <= 1'b0;
    end else if (count != '0) begin
      count    <= count - cnt_w'(1);
      div_done <= last_step;
    end else begin
      div_done <= 1'b0;
    end
  end

  // Remainder and quotient shift
  always_ff @(posedge clk) begin
    if (div_start) begin
      divisor_q <= divisor;
      rem_q     <= next_rem << 1;
      quotient  <= fp_format_pkg::quot_t'(q_bit);
    end else if (count != '0) begin
      rem_q    <= next_rem << 1;
      quotient <= {quotient[`FPDIV_QUOT_W-2:0], q_bit};
      // Leftover remainder marks the quotient as inexact
      if (last_step) begin
        sticky <= (next_rem != '0);
      end
    end
  end

  // A new operand pair must not cut into a running division
  a_no_restart: assert property (
    @(posedge clk) disable iff (!reset_n) div_start |-> (count == '0)
  );

endmodule

//--- hw/fp_round_pack.sv
// ==========================================================================
// Normalize, round and pack the raw quotient into a single result
// Takes one cycle from rp_start to rp_done, flushes underflow to zero
// ==========================================================================

`include "fpdiv_settings.svh"

module fp_round_pack (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        rp_start,
  input  logic                        sign,
  input  fp_format_pkg::exp_wide_t    exp_in,
  input  fp_format_pkg::quot_t        quotient,
  input  logic                        sticky_in,
  input  fpdiv_ctrl_pkg::round_mode_e rounding_mode,
  output logic                        rp_done,
  output fp_format_pkg::float_t       result,
  output fpdiv_ctrl_pkg::fp_flags_t   flags
);

  logic                      guard;
  logic                      sticky_all;
  logic                      inexact;
  logic                      round_up;
  logic                      carry;
  fp_format_pkg::sig_t       kept;
  logic [`FPDIV_MAN_W+1:0]   rounded;
  fp_format_pkg::exp_wide_t  exp_adj;
  fp_format_pkg::exp_wide_t  exp_final;
  fp_format_pkg::float_t     result_c;
  fpdiv_ctrl_pkg::fp_flags_t flags_c;

  // Normalize
  always_comb begin
    if (quotient[`FPDIV_QUOT_W-1]) begin
      // Quotient in [1,2), no shift
      kept       = quotient[`FPDIV_QUOT_W-1:2];
      guard      = quotient[1];
      sticky_all = quotient[0] | sticky_in;
      exp_adj    = exp_in;
    end else begin
      // Quotient in (0.5,1), one place left
      kept       = quotient[`FPDIV_QUOT_W-2:1];
      guard      = quotient[0];
      sticky_all = sticky_in;
      exp_adj    = exp_in - fp_format_pkg::exp_wide_t'(1);
    end
  end

  // Round
  always_comb begin
    inexact = guard | sticky_all;
    case (rounding_mode)
      fpdiv_ctrl_pkg::rne: round_up = guard & (sticky_all | kept[0]);
      fpdiv_ctrl_pkg::rdn: round_up = sign & inexact;
      fpdiv_ctrl_pkg::rup: round_up = ~sign & inexact;
      fpdiv_ctrl_pkg::rmm: round_up = guard;
      // rtz and the reserved encodings truncate
      default:             round_up = 1'b0;
    endcase
    rounded   = {1'b0, kept} + (`FPDIV_MAN_W+2)'(round_up);
    // All ones rounded up becomes 1.0 of the next binade
    carry     = rounded[`FPDIV_MAN_W+1];
    exp_final = carry ? exp_adj + fp_format_pkg::exp_wide_t'(1) : exp_adj;
  end

  // Pack with range checks
  always_comb begin
    flags_c = '0;
    if (exp_adj < fp_format_pkg::exp_wide_t'(1)) begin
      // Below the normal range, flushed to signed zero
      result_c   = {sign, {(`FPDIV_EXP_W+`FPDIV_MAN_W){1'b0}}};
      flags_c.uf = 1'b1;
      flags_c.nx = 1'b1;
    end else if (exp_final >= fp_format_pkg::exp_wide_t'((1 << `FPDIV_EXP_W) - 1)) begin
      // Signed infinity whatever the mode
      result_c   = {sign, {`FPDIV_EXP_W{1'b1}}, {`FPDIV_MAN_W{1'b0}}};
      flags_c.of = 1'b1;
      flags_c.nx = 1'b1;
    end else begin
      result_c   = {sign, exp_final[`FPDIV_EXP_W-1:0], rounded[`FPDIV_MAN_W-1:0]};
      flags_c.nx = inexact;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rp_done <= 1'b0;
    end else begin
      rp_done <= rp_start;
    end
  end

  // Held until the next rp_start
  always_ff @(posedge clk) begin
    if (rp_start) begin
      result <= result_c;
      flags  <= flags_c;
    end
  end

endmodule

//--- hw/fp_divider.sv
// ==========================================================================
// Single-precision floating-point divide unit for FDIV.S
// start in idle loads the operands, done pulses once with result and flags
// Special cases finish 3 cycles after acceptance, divisions 31 cycles after
// ==========================================================================

`include "fpdiv_settings.svh"

module fp_divider (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        start,
  input  fpdiv_ctrl_pkg::round_mode_e rounding_mode,
  input  fp_format_pkg::float_t       operand_a,
  input  fp_format_pkg::float_t       operand_b,
  output logic                        busy,
  output logic                        done,
  output fp_format_pkg::float_t       result,
  output fpdiv_ctrl_pkg::fp_flags_t   flags
);

  fpdiv_ctrl_pkg::div_state_e  state;
  fpdiv_ctrl_pkg::round_mode_e rm_q;
  fp_format_pkg::float_t       op_a_q;
  fp_format_pkg::float_t       op_b_q;
  fp_format_pkg::fp_unpacked_t ua_c;
  fp_format_pkg::fp_unpacked_t ub_c;
  fp_format_pkg::fp_unpacked_t ua_q;
  fp_format_pkg::fp_unpacked_t ub_q;
  logic                        cls_valid;

  logic                        res_sign;
  fp_format_pkg::exp_wide_t    exp_diff;
  logic                        special;
  fp_format_pkg::float_t       spec_result;
  fpdiv_ctrl_pkg::fp_flags_t   spec_flags;

  logic                        div_start;
  logic                        div_done;
  fp_format_pkg::quot_t        quotient;
  logic                        quot_sticky;
  logic                        rp_start;
  logic                        rp_done;
  fp_format_pkg::float_t       rp_result;
  fpdiv_ctrl_pkg::fp_flags_t   rp_flags;
  fp_format_pkg::float_t       res_pend;
  fpdiv_ctrl_pkg::fp_flags_t   flg_pend;

  // ==========================================================================
  // Datapath blocks
  // ==========================================================================

  fp_classify cls_a_i (.operand(op_a_q), .unpacked(ua_c));
  fp_classify cls_b_i (.operand(op_b_q), .unpacked(ub_c));

  mant_divider div_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .div_start(div_start),
    .dividend (ua_q.sig),
    .divisor  (ub_q.sig),
    .div_done (div_done),
    .quotient (quotient),
    .sticky   (quot_sticky)
  );

  fp_round_pack rp_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .rp_start     (rp_start),
    .sign         (res_sign),
    .exp_in       (exp_diff),
    .quotient     (quotient),
    .sticky_in    (quot_sticky),
    .rounding_mode(rm_q),
    .rp_done      (rp_done),
    .result       (rp_result),
    .flags        (rp_flags)
  );

  assign res_sign = ua_q.sign ^ ub_q.sign;
  // Biased exponent of the quotient before normalization
  assign exp_diff = fp_format_pkg::exp_wide_t'({2'b00, ua_q.exp})
                  - fp_format_pkg::exp_wide_t'({2'b00, ub_q.exp})
                  + fp_format_pkg::exp_wide_t'(`FPDIV_BIAS);

  // Special-case table, NaNs first
  always_comb begin
    special     = 1'b1;
    spec_flags  = '0;
    spec_result = {res_sign, {`FPDIV_EXP_W{1'b1}}, {`FPDIV_MAN_W{1'b0}}};
    if (ua_q.cls == fp_format_pkg::cls_snan || ub_q.cls == fp_format_pkg::cls_snan) begin
      spec_result   = `FPDIV_QNAN;
      spec_flags.nv = 1'b1;
    end else if (ua_q.cls == fp_format_pkg::cls_qnan ||
                 ub_q.cls == fp_format_pkg::cls_qnan) begin
      spec_result = `FPDIV_QNAN;
    end else if (ua_q.cls == ub_q.cls && (ua_q.cls == fp_format_pkg::cls_zero ||
                                          ua_q.cls == fp_format_pkg::cls_inf)) begin
      // 0/0 and inf/inf
      spec_result   = `FPDIV_QNAN;
      spec_flags.nv = 1'b1;
    end else if (ua_q.cls == fp_format_pkg::cls_inf) begin
      spec_result = {res_sign, {`FPDIV_EXP_W{1'b1}}, {`FPDIV_MAN_W{1'b0}}};
    end else if (ub_q.cls == fp_format_pkg::cls_inf ||
                 ua_q.cls == fp_format_pkg::cls_zero) begin
      spec_result = {res_sign, {(`FPDIV_EXP_W+`FPDIV_MAN_W){1'b0}}};
    end else if (ub_q.cls == fp_format_pkg::cls_zero) begin
      spec_flags.dz = 1'b1;
    end else begin
      special = 1'b0;
    end
  end

  // ==========================================================================
  // Operation FSM
  // ==========================================================================

  // Second classify cycle launches the divider when nothing special applies
  assign div_start = (state == fpdiv_ctrl_pkg::classify) && cls_valid && !special;
  assign busy      = (state != fpdiv_ctrl_pkg::idle);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= fpdiv_ctrl_pkg::idle;
      cls_valid <= 1'b0;
      rp_start  <= 1'b0;
      done      <= 1'b0;
      result    <= '0;
      flags     <= '0;
    end else begin
      done     <= 1'b0;
      rp_start <= 1'b0;
      case (state)
        fpdiv_ctrl_pkg::idle: begin
          if (start) begin
            state <= fpdiv_ctrl_pkg::classify;
          end
        end
        fpdiv_ctrl_pkg::classify: begin
          // First cycle captures the classes, second one decides
          cls_valid <= !cls_valid;
          if (cls_valid) begin
            state <= special ? fpdiv_ctrl_pkg::finish : fpdiv_ctrl_pkg::divide;
          end
        end
        fpdiv_ctrl_pkg::divide: begin
          if (div_done) begin
            rp_start <= 1'b1;
            state    <= fpdiv_ctrl_pkg::round;
          end
        end
        fpdiv_ctrl_pkg::round: begin
          if (rp_done) begin
            state <= fpdiv_ctrl_pkg::finish;
          end
        end
        default: begin
          result <= res_pend;
          flags  <= flg_pend;
          done   <= 1'b1;
          state  <= fpdiv_ctrl_pkg::idle;
        end
      endcase
    end
  end

  // Operand, class and pending result capture
  always_ff @(posedge clk) begin
    if (state == fpdiv_ctrl_pkg::idle && start) begin
      op_a_q <= operand_a;
      op_b_q <= operand_b;
      rm_q   <= rounding_mode;
    end
    if (state == fpdiv_ctrl_pkg::classify && !cls_valid) begin
      ua_q <= ua_c;
      ub_q <= ub_c;
    end
    if (state == fpdiv_ctrl_pkg::classify && cls_valid && special) begin
      res_pend <= spec_result;
      flg_pend <= spec_flags;
    end else if (state == fpdiv_ctrl_pkg::round && rp_done) begin
      res_pend <= rp_result;
      flg_pend <= rp_flags;
    end
  end

  a_done_not_busy: assert property (
    @(posedge clk) disable iff (!reset_n) !(done && busy)
  );

  a_done_single: assert property (
    @(posedge clk) disable iff (!reset_n) done |=> !done
  );

endmodule

//--- verif/fp_div_ref.svh
// ==========================================================================
// Reference model of the single divide and the random number source
// Included inside the testbench module, returns {flags, result}
// ==========================================================================

`ifndef FP_DIV_REF_SVH
`define FP_DIV_REF_SVH

// Galois LFSR, one step per random bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 32'h8020_0003;
  end
  return n;
endfunction

// Flags in the order nv dz of uf nx above the 32-bit result
function automatic logic [36:0] div_reference(input logic [31:0] a, input logic [31:0] b,
                                              input logic [2:0] rm);
  logic        s;
  int          ea;
  int          eb;
  int          e;
  logic        a_nan, a_snan, a_inf, a_zero;
  logic        b_nan, b_snan, b_inf, b_zero;
  logic [63:0] num;
  logic [63:0] den;
  logic [63:0] q;
  logic [24:0] kept;
  logic        guard, sticky, inexact, up;
  logic [7:0]  exp8;
  s      = a[31] ^ b[31];
  ea     = int'(a[30:23]);
  eb     = int'(b[30:23]);
  a_nan  = (ea == 255) && (a[22:0] != 23'h0);
  a_snan = a_nan && !a[22];
  a_inf  = (ea == 255) && (a[22:0] == 23'h0);
  a_zero = (ea == 0);
  b_nan  = (eb == 255) && (b[22:0] != 23'h0);
  b_snan = b_nan && !b[22];
  b_inf  = (eb == 255) && (b[22:0] == 23'h0);
  b_zero = (eb == 0);
  // Special cases, NaNs first, subnormals already count as zero
  if (a_snan || b_snan) return {5'b10000, 32'h7fc0_0000};
  if (a_nan || b_nan) return {5'b00000, 32'h7fc0_0000};
  if ((a_zero && b_zero) || (a_inf && b_inf)) return {5'b10000, 32'h7fc0_0000};
  if (a_inf) return {5'b00000, s, 8'hff, 23'h0};
  if (b_inf || a_zero) return {5'b00000, s, 31'h0};
  if (b_zero) return {5'b01000, s, 8'hff, 23'h0};
  // Long division, 24 quotient bits plus guard
  num = {40'h0, 1'b1, a[22:0]};
  den = {40'h0, 1'b1, b[22:0]};
  e   = ea - eb + 127;
  if (num < den) begin
    num = num << 1;
    e   = e - 1;
  end
  num    = num << 24;
  q      = num / den;
  sticky = (num % den) != 64'h0;
  guard  = q[0];
  kept   = 25'(q >> 1);
  // Below the normal range before rounding
  if (e < 1) return {5'b00011, s, 31'h0};
  inexact = guard | sticky;
  case (rm)
    3'd0:    up = guard & (sticky | kept[0]);
    3'd2:    up = s & inexact;
    3'd3:    up = ~s & inexact;
    3'd4:    up = guard;
    default: up = 1'b0;
  endcase
  kept = kept + 25'(up);
  if (kept[24]) begin
    kept = kept >> 1;
    e    = e + 1;
  end
  if (e >= 255) return {5'b00101, s, 8'hff, 23'h0};
  exp8 = 8'(e);
  return {4'b0000, inexact, s, exp8, kept[22:0]};
endfunction

`endif

//--- verif/fp_divider_tb.sv
// ==========================================================================
// Testbench of the single-precision divide unit
// Directed special, range and timing cases, then random normal divisions
// ==========================================================================

module fp_divider_tb;

  localparam int wait_limit = 40;

  logic                        clk;
  logic                        reset_n;
  logic                        start;
  fpdiv_ctrl_pkg::round_mode_e rounding_mode;
  fp_format_pkg::float_t       operand_a;
  fp_format_pkg::float_t       operand_b;
  logic                        busy;
  logic                        done;
  fp_format_pkg::float_t       result;
  fpdiv_ctrl_pkg::fp_flags_t   flags;

  // Expected values in issue order, popped when done pulses
  logic [31:0] exp_res_q[$];
  logic [4:0]  exp_flg_q[$];
  logic [31:0] cmp_res;
  logic [4:0]  cmp_flg;
  logic [31:0] lfsr_state;
  logic        aborted;
  int          value_errors;
  int          timing_errors;
  int          protocol_errors;
  int          timeouts;
  int          ops_checked;

  `include "fp_div_ref.svh"

  fp_divider dut_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .start        (start),
    .rounding_mode(rounding_mode),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .busy         (busy),
    .done         (done),
    .result       (result),
    .flags        (flags)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
    value_errors++;
  endtask

  // Takes n bits, one LFSR step each
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] val;
    int          i;
    val = 32'h0;
    for (i = 0; i < n; i++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return val;
  endfunction

  // Exponent kept in 64..191, so most quotients stay normal
  function automatic logic [31:0] random_operand();
    logic [31:0] sgn;
    logic [31:0] ex;
    logic [31:0] fr;
    sgn = random_bits(1);
    ex  = random_bits(7);
    fr  = random_bits(23);
    return {sgn[0], 8'd64 + {1'b0, ex[6:0]}, fr[22:0]};
  endfunction

  // Queue the expectation and pulse start for one cycle
  task automatic start_op(input logic [31:0] a, input logic [31:0] b, input logic [2:0] rm,
                          input logic [31:0] er, input logic [4:0] ef);
    exp_res_q.push_back(er);
    exp_flg_q.push_back(ef);
    @(negedge clk);
    operand_a     = a;
    operand_b     = b;
    rounding_mode = fpdiv_ctrl_pkg::round_mode_e'(rm);
    start         = 1'b1;
    @(negedge clk);
    // Inputs scrambled after acceptance
    start         = 1'b0;
    operand_a     = ~a;
    operand_b     = ~b;
    rounding_mode = fpdiv_ctrl_pkg::round_mode_e'(~rm);
  endtask

  // Counts cycles since the accepting edge
  task automatic wait_done(input int exp_lat, input int already);
    int   cycles;
    logic seen;
    cycles = already;
    seen   = 1'b0;
    while (!seen && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
      seen = done;
    end
    if (!seen) begin
      $display("Timeout: no done within %0d cycles of start", wait_limit);
      timeouts++;
      aborted = 1'b1;
    end else if (cycles != exp_lat) begin
      $display("Wrong latency: done came %0d cycles after start, expected %0d",
               cycles, exp_lat);
      timing_errors++;
    end
  endtask

  task automatic run_div(input logic [31:0] a, input logic [31:0] b, input logic [2:0] rm,
                         input logic [31:0] er, input logic [4:0] ef, input int lat);
    if (aborted) return;
    start_op(a, b, rm, er, ef);
    wait_done(lat, 0);
  endtask

  // Outputs must hold after done
  task automatic check_hold(input int n, input logic [31:0] er, input logic [4:0] ef);
    repeat (n) begin
      @(negedge clk);
      if (result !== er) report_mismatch("result", result, er);
      if (flags !== ef) report_mismatch("flags", 32'(flags), 32'(ef));
    end
  endtask

  // Second start during a running divide is dropped
  task automatic hold_after_busy_start();
    if (aborted) return;
    start_op(32'h3f80_0000, 32'h4040_0000, 3'd0, 32'h3eaa_aaab, 5'b00001);
    @(negedge clk);
    if (busy !== 1'b1) report_mismatch("busy", 32'(busy), 32'd1);
    operand_a = 32'h40c0_0000;
    operand_b = 32'h4000_0000;
    start     = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait_done(31, 2);
    check_hold(12, 32'h3eaa_aaab, 5'b00001);
  endtask

  // ==========================================================================
  // Comparing process
  // ==========================================================================

  always @(negedge clk) begin
    if (reset_n) begin
      if (done && busy) begin
        $display("Protocol error: done and busy high in the same cycle");
        protocol_errors++;
      end
      if (done) begin
        if (exp_res_q.size() == 0) begin
          $display("Protocol error: done pulsed with no operation pending");
          protocol_errors++;
        end else begin
          cmp_res = exp_res_q.pop_front();
          cmp_flg = exp_flg_q.pop_front();
          if (result !== cmp_res) report_mismatch("result", result, cmp_res);
          if (flags !== cmp_flg) report_mismatch("flags", 32'(flags), 32'(cmp_flg));
          ops_checked++;
        end
      end
    end
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  initial begin
    logic [36:0] ref_val;
    logic [31:0] ra;
    logic [31:0] rb;
    int          i;
    start           = 1'b0;
    operand_a       = 32'h0;
    operand_b       = 32'h0;
    rounding_mode   = fpdiv_ctrl_pkg::rne;
    reset_n         = 1'b0;
    lfsr_state      = 32'd75;
    aborted         = 1'b0;
    value_errors    = 0;
    timing_errors   = 0;
    protocol_errors = 0;
    timeouts        = 0;
    ops_checked     = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // Outputs after reset
    @(negedge clk);
    if (busy !== 1'b0) report_mismatch("busy", 32'(busy), 32'd0);
    if (done !== 1'b0) report_mismatch("done", 32'(done), 32'd0);
    if (result !== 32'h0) report_mismatch("result", result, 32'h0);
    if (flags !== 5'b0) report_mismatch("flags", 32'(flags), 32'd0);

    // Exact and rounded quotients, each mode
    run_div(32'h40c0_0000, 32'h4000_0000, 3'd0, 32'h4040_0000, 5'b00000, 31);
    run_div(32'h3f80_0000, 32'h4040_0000, 3'd0, 32'h3eaa_aaab, 5'b00001, 31);
    run_div(32'h3f80_0000, 32'h4040_0000, 3'd1, 32'h3eaa_aaaa, 5'b00001, 31);
    run_div(32'hbf80_0000, 32'h4040_0000, 3'd2, 32'hbeaa_aaab, 5'b00001, 31);
    run_div(32'hbf80_0000, 32'h4040_0000, 3'd3, 32'hbeaa_aaaa, 5'b00001, 31);
    run_div(32'h3f80_0000, 32'h4040_0000, 3'd4, 32'h3eaa_aaab, 5'b00001, 31);
    // Reserved encoding truncates
    run_div(32'h3f80_0000, 32'h4040_0000, 3'd5, 32'h3eaa_aaaa, 5'b00001, 31);

    // Special-case table
    run_div(32'h7f80_0001, 32'h3f80_0000, 3'd0, 32'h7fc0_0000, 5'b10000, 3);
    run_div(32'h3f80_0000, 32'hff80_0001, 3'd0, 32'h7fc0_0000, 5'b10000, 3);
    run_div(32'h7fc0_0000, 32'h4000_0000, 3'd0, 32'h7fc0_0000, 5'b00000, 3);
    run_div(32'h7f80_0001, 32'h7fc0_0000, 3'd0, 32'h7fc0_0000, 5'b10000, 3);
    run_div(32'h0000_0000, 32'h8000_0000, 3'd0, 32'h7fc0_0000, 5'b10000, 3);
    run_div(32'hff80_0000, 32'h7f80_0000, 3'd0, 32'h7fc0_0000, 5'b10000, 3);
    run_div(32'h7f80_0000, 32'hc000_0000, 3'd0, 32'hff80_0000, 5'b00000, 3);
    run_div(32'hc000_0000, 32'h7f80_0000, 3'd0, 32'h8000_0000, 5'b00000, 3);
    run_div(32'h8000_0000, 32'h4040_0000, 3'd0, 32'h8000_0000, 5'b00000, 3);
    run_div(32'h4040_0000, 32'h8000_0000, 3'd0, 32'hff80_0000, 5'b01000, 3);
    // Subnormals act as zero
    run_div(32'h0000_0001, 32'h3f80_0000, 3'd0, 32'h0000_0000, 5'b00000, 3);
    run_div(32'h3f80_0000, 32'h8040_0000, 3'd0, 32'hff80_0000, 5'b01000, 3);
    run_div(32'h0000_0001, 32'h807f_ffff, 3'd0, 32'h7fc0_0000, 5'b10000, 3);

    // Overflow and underflow
    run_div(32'h7f00_0000, 32'h3e80_0000, 3'd0, 32'h7f80_0000, 5'b00101, 31);
    run_div(32'hff00_0000, 32'h3f00_0000, 3'd1, 32'hff80_0000, 5'b00101, 31);
    run_div(32'h0080_0000, 32'h4000_0000, 3'd0, 32'h0000_0000, 5'b00011, 31);
    run_div(32'h8080_0000, 32'h4080_0000, 3'd3, 32'h8000_0000, 5'b00011, 31);

    hold_after_busy_start();

    // Random normals, modes in turn
    for (i = 0; i < 250; i++) begin
      ra      = random_operand();
      rb      = random_operand();
      ref_val = div_reference(ra, rb, 3'(i % 5));
      run_div(ra, rb, 3'(i % 5), ref_val[31:0], ref_val[36:32], 31);
    end

    repeat (4) @(negedge clk);
    if (exp_res_q.size() != 0) begin
      $display("Protocol error: %0d operations never finished", exp_res_q.size());
      protocol_errors++;
    end
    $display("Summary: %0d checked, %0d value, %0d timing, %0d protocol, %0d timeout errors",
             ops_checked, value_errors, timing_errors, protocol_errors, timeouts);
    if (value_errors + timing_errors + protocol_errors + timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+hw
+incdir+verif
hw/fp_format_pkg.sv
hw/fpdiv_ctrl_pkg.sv
hw/fp_classify.sv
hw/mant_divider.sv
hw/fp_round_pack.sv
hw/fp_divider.sv
verif/fp_divider_tb.sv

//--- Makefile
# Verilator build of the single-precision divide unit and its testbench

VERILATOR  ?= verilator
FILELIST   := list.f
TOP        := fp_divider_tb
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := *** TEST PASSED ***
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
